/* image_pyramid.f */
verilog/image_pkg.sv
verilog/uart_pkg.sv
verilog/uart_receiver.sv
verilog/uart_transmitter.sv
verilog/pixel_ram.sv
verilog/box_downsampler.sv
verilog/pyramid_controller.sv
verilog/pyramid_top.sv
verification/pyramid_checker.sv
verification/tb_image_pyramid.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the image_pyramid testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_image_pyramid \
    -Mdir "$BUILD_DIR" -o sim_image_pyramid -f image_pyramid.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/sim_image_pyramid" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG_FILE"; then
    exit 1
fi
exit 0

/* verification/pyramid_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module pyramid_checker
    import image_pkg::*;
    import uart_pkg::*;
#(
    parameter int IMG_WIDTH = 8,
    parameter int IMG_HEIGHT = 8,
    parameter int CLOCKS_PER_BAUD = 4,
    parameter int EXPECTED_PASSES = 2
) (
    input wire clk_100mhz,
    input wire sys_rst,
    input wire rxd_i,
    input wire send_i,
    input wire txd_i,
    input wire image_ready_i,
    input wire reduced_ready_i,
    input wire sending_i,
    input wire pixel_t image_i [IMG_WIDTH*IMG_HEIGHT],
    input wire finish_i,
    output int error_count_o,
    output int rx_frames_o,
    output int tx_frames_o
);
    localparam int NUM_PIXELS = IMG_WIDTH * IMG_HEIGHT;
    localparam int NUM_REDUCED = NUM_PIXELS / 4;

    int err_rx = 0;
    int err_tx = 0;
    int err_ctrl = 0;
    int err_final = 0;
    int rx_frames = 0;
    int tx_frames = 0;
    int pass_frames = 0;
    int passes = 0;
    logic sending_seen;
    logic rst_seen = 1'b0;
    logic send_q;
    logic send_pending;
    logic send_expect;
    logic final_done = 1'b0;
    pixel_t rx_byte;
    pixel_t tx_byte;
    logic rx_start_ok;
    logic rx_stop_ok;
    logic tx_start_ok;
    logic tx_stop_ok;

    assign error_count_o = err_rx + err_tx + err_ctrl + err_final;
    assign rx_frames_o = rx_frames;
    assign tx_frames_o = tx_frames;

    // floored mean of the 2x2 input block behind reduced pixel index
    function automatic pixel_t box_average(int index);
        int ox;
        int oy;
        int base;
        int sum;
        ox = index % (IMG_WIDTH / 2);
        oy = index / (IMG_WIDTH / 2);
        base = 2 * oy * IMG_WIDTH + 2 * ox;
        sum = int'(image_i[base]) + int'(image_i[base + 1])
            + int'(image_i[base + IMG_WIDTH]) + int'(image_i[base + IMG_WIDTH + 1]);
        return pixel_t'(sum / 4);
    endfunction

    function automatic int differs(string name, int expected, int actual);
        int bad;
        bad = 0;
        if (expected != actual) begin
            $display("Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            bad = 1;
        end
        return bad;
    endfunction

    function automatic logic line_value(bit tx_line);
        return tx_line ? txd_i : rxd_i;
    endfunction

    // called on the first low sample, then samples each bit in its middle
    task automatic sample_frame(input bit tx_line, output pixel_t data,
                                output logic start_ok, output logic stop_ok);
        repeat (CLOCKS_PER_BAUD / 2) @(posedge clk_100mhz);
        start_ok = !line_value(tx_line);
        for (int i = 0; i < UART_DATA_BITS; i++) begin
            repeat (CLOCKS_PER_BAUD) @(posedge clk_100mhz);
            data[i] = line_value(tx_line);    // lsb first
        end
        repeat (CLOCKS_PER_BAUD) @(posedge clk_100mhz);
        stop_ok = line_value(tx_line);
    endtask

    // incoming image frames and the image_ready_o level around them
    initial begin
        forever begin
            @(posedge clk_100mhz);
            if (!sys_rst && !rxd_i) begin
                err_rx += differs("image_ready_o", int'(rx_frames >= NUM_PIXELS), image_ready_i);
                sample_frame(1'b0, rx_byte, rx_start_ok, rx_stop_ok);
                if (rx_frames == NUM_PIXELS - 1) begin
                    err_rx += differs("image_ready_o", 0, image_ready_i);    // strobe not yet out
                end
                if (rx_start_ok && rx_stop_ok) begin
                    if (rx_frames < NUM_PIXELS) begin
                        err_rx += differs($sformatf("uart_rxd_i pixel %0d", rx_frames),
                                          image_i[rx_frames], rx_byte);
                    end
                    rx_frames++;
                end
            end
        end
    end

    // reduced image frames on uart_txd_o
    initial begin
        sending_seen = 1'b0;
        forever begin
            @(posedge clk_100mhz);
            if (sys_rst) begin
                sending_seen = 1'b0;
            end else begin
                if (sending_i && !sending_seen) begin
                    pass_frames = 0;    // each pass restarts at pixel 0
                end else if (!sending_i && sending_seen) begin
                    err_tx += differs("frames in send pass", NUM_REDUCED, pass_frames);
                    passes++;
                end
                sending_seen = sending_i;
                if (!txd_i) begin
                    if (!sending_i) begin
                        $display("Error at %0t: start bit on uart_txd_o while sending_o is low",
                                 $time);
                        err_tx++;
                    end
                    sample_frame(1'b1, tx_byte, tx_start_ok, tx_stop_ok);
                    if (!tx_start_ok || !tx_stop_ok) begin
                        $display("Error at %0t: bad start or stop bit on uart_txd_o", $time);
                        err_tx++;
                    end
                    err_tx += differs("sending_o", 1, sending_i);    // held through the stop bit
                    if (pass_frames < NUM_REDUCED) begin
                        err_tx += differs($sformatf("uart_txd_o pixel %0d", pass_frames),
                                          box_average(pass_frames), tx_byte);
                    end else begin
                        $display("Error at %0t: more than %0d frames in one send pass",
                                 $time, NUM_REDUCED);
                        err_tx++;
                    end
                    pass_frames++;
                    tx_frames++;
                end
            end
        end
    end

    // reset values, then the response to each send_i edge
    always @(posedge clk_100mhz) begin
        if (sys_rst) begin
            rst_seen <= 1'b1;
            send_q <= 1'b0;
            send_pending <= 1'b0;
        end else begin
            rst_seen <= 1'b0;
            if (rst_seen) begin
                err_ctrl <= err_ctrl + differs("image_ready_o", 0, image_ready_i)
                    + differs("reduced_ready_o", 0, reduced_ready_i)
                    + differs("sending_o", 0, sending_i)
                    + differs("uart_txd_o", 1, txd_i);
            end else if (send_pending) begin
                err_ctrl <= err_ctrl + differs("sending_o", send_expect, sending_i);
            end
            send_q <= send_i;
            send_pending <= send_i && !send_q && !sending_i;    // edges mid pass are ignored
            send_expect <= reduced_ready_i;
        end
    end

    always @(posedge clk_100mhz) begin
        if (finish_i && !final_done) begin
            final_done <= 1'b1;
            err_final <= differs("completed send passes", EXPECTED_PASSES, passes)
                + differs("sending_o", 0, sending_i)
                + differs("reduced_ready_o", 1, reduced_ready_i);
        end
    end

endmodule

`default_nettype wire

/* verification/tb_image_pyramid.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_image_pyramid
    import image_pkg::*;
    import uart_pkg::*;
();
    localparam int IMG_WIDTH = 8;
    localparam int IMG_HEIGHT = 8;
    localparam int CLOCKS_PER_BAUD = 4;
    localparam int NUM_PIXELS = IMG_WIDTH * IMG_HEIGHT;
    localparam int NUM_REDUCED = NUM_PIXELS / 4;
    localparam int EXTRA_BYTES = 4;
    localparam int FRAME_CYCLES = UART_FRAME_BITS * CLOCKS_PER_BAUD;
    localparam int WATCHDOG_CYCLES = 2 * (NUM_PIXELS + 2 * NUM_REDUCED) * FRAME_CYCLES + 2000;
    localparam logic [31:0] RANDOM_SEED = 32'h2fb6c32c;

    logic clk_100mhz = 1'b0;
    logic sys_rst;
    logic uart_rxd;
    logic send_req;
    logic finish_check;
    wire uart_txd;
    wire image_ready;
    wire reduced_ready;
    wire sending;
    int error_count;
    int rx_frames;
    int tx_frames;
    pixel_t image [NUM_PIXELS];
    pixel_t extra [EXTRA_BYTES];

    always #5 clk_100mhz = ~clk_100mhz;

    pyramid_top #(
        .IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT), .CLOCKS_PER_BAUD(CLOCKS_PER_BAUD)
    ) dut0 (
        .clk_100mhz(clk_100mhz), .sys_rst(sys_rst), .uart_rxd_i(uart_rxd),
        .send_i(send_req), .uart_txd_o(uart_txd), .image_ready_o(image_ready),
        .reduced_ready_o(reduced_ready), .sending_o(sending)
    );

    pyramid_checker #(
        .IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT),
        .CLOCKS_PER_BAUD(CLOCKS_PER_BAUD), .EXPECTED_PASSES(2)
    ) checker0 (
        .clk_100mhz(clk_100mhz), .sys_rst(sys_rst), .rxd_i(uart_rxd), .send_i(send_req),
        .txd_i(uart_txd), .image_ready_i(image_ready), .reduced_ready_i(reduced_ready),
        .sending_i(sending), .image_i(image), .finish_i(finish_check),
        .error_count_o(error_count), .rx_frames_o(rx_frames), .tx_frames_o(tx_frames)
    );

    // 8N1 frame after an idle gap of 0 to 3 bit times
    task automatic send_byte(input pixel_t value);
        int gap;
        logic [UART_FRAME_BITS-1:0] frame;
        gap = $urandom % 4;
        frame = {1'b1, value, 1'b0};    // stop, data, start
        repeat (gap * CLOCKS_PER_BAUD) @(negedge clk_100mhz);
        for (int i = 0; i < UART_FRAME_BITS; i++) begin
            uart_rxd = frame[i];
            repeat (CLOCKS_PER_BAUD) @(negedge clk_100mhz);
        end
    endtask

    task automatic pulse_send();
        @(negedge clk_100mhz);
        send_req = 1'b1;
        repeat (3) @(negedge clk_100mhz);
        send_req = 1'b0;
    endtask

    initial begin
        sys_rst = 1'b1;
        uart_rxd = 1'b1;    // idle line
        send_req = 1'b0;
        finish_check = 1'b0;
        void'($urandom(RANDOM_SEED));
        for (int i = 0; i < NUM_PIXELS; i++) begin
            image[i] = pixel_t'($urandom);
        end
        for (int i = 0; i < EXTRA_BYTES; i++) begin
            extra[i] = pixel_t'($urandom);
        end
        repeat (4) @(negedge clk_100mhz);
        sys_rst = 1'b0;
        pulse_send();    // nothing to send yet
        for (int i = 0; i < NUM_PIXELS; i++) begin
            send_byte(image[i]);
        end
        while (!image_ready) @(negedge clk_100mhz);
        pulse_send();    // downsampler still busy
        for (int i = 0; i < EXTRA_BYTES; i++) begin
            send_byte(extra[i]);
        end
        while (!reduced_ready) @(negedge clk_100mhz);
        pulse_send();
        while (!sending) @(negedge clk_100mhz);
        repeat (3 * FRAME_CYCLES) @(negedge clk_100mhz);
        pulse_send();    // mid pass, must not restart
        while (sending) @(negedge clk_100mhz);
        repeat (FRAME_CYCLES) @(negedge clk_100mhz);
        pulse_send();
        while (!sending) @(negedge clk_100mhz);
        while (sending) @(negedge clk_100mhz);
        repeat (FRAME_CYCLES) @(negedge clk_100mhz);
        finish_check = 1'b1;
        @(negedge clk_100mhz);
        $display("errors: %0d, frames received: %0d, frames sent: %0d",
                 error_count, rx_frames, tx_frames);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_100mhz);
        $display("Timeout: the test did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/box_downsampler.sv */
`timescale 1ns/1ps
`default_nettype none

module box_downsampler
    import image_pkg::*;
#(
    parameter int IMG_WIDTH = 64,
    parameter int IMG_HEIGHT = 64
) (
    input wire clk_100mhz,
    input wire sys_rst,
    input wire start_i,
    output logic busy_o,
    output logic done_o,
    output logic [$clog2(IMG_WIDTH*IMG_HEIGHT)-1:0] src_addr_o,
    input wire pixel_t src_data_i,
    output logic dst_we_o,
    output logic [$clog2(IMG_WIDTH*IMG_HEIGHT/4)-1:0] dst_addr_o,
    output pixel_t dst_data_o
);
    localparam int OUT_W = IMG_WIDTH / 2;
    localparam int OUT_H = IMG_HEIGHT / 2;
    localparam int SRC_BITS = $clog2(IMG_WIDTH * IMG_HEIGHT);
    localparam int DST_BITS = $clog2(OUT_W * OUT_H);
    localparam int X_BITS = $clog2(IMG_WIDTH);
    localparam int Y_BITS = $clog2(IMG_HEIGHT);

    logic issuing;
    logic last_block;
    logic [X_BITS-1:0] ox;
    logic [Y_BITS-1:0] oy;
    logic [1:0] phase;    // bit 0 picks column, bit 1 picks row
    logic rd_valid;
    logic rd_last;
    logic [1:0] rd_phase;
    logic [DST_BITS-1:0] rd_addr;
    logic [BLOCK_SUM_BITS-1:0] sum;
    logic [BLOCK_SUM_BITS-1:0] block_sum;
    logic wr_last;

    assign last_block = (ox == X_BITS'(OUT_W - 1)) && (oy == Y_BITS'(OUT_H - 1));
    assign src_addr_o = SRC_BITS'((2 * oy + phase[1]) * IMG_WIDTH + 2 * ox + phase[0]);

    // restart the sum on the first pixel of a block
    assign block_sum = (rd_phase == 2'd0 ? '0 : sum) + BLOCK_SUM_BITS'(src_data_i);

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            issuing <= 1'b0;
            busy_o <= 1'b0;
            ox <= '0;
            oy <= '0;
            phase <= '0;
            rd_valid <= 1'b0;
            rd_last <= 1'b0;
            rd_phase <= '0;
            dst_we_o <= 1'b0;
            wr_last <= 1'b0;
            done_o <= 1'b0;
        end else begin
            if (start_i) begin
                issuing <= 1'b1;
                busy_o <= 1'b1;
                ox <= '0;
                oy <= '0;
                phase <= '0;
            end else if (issuing) begin
                phase <= phase + 1'b1;
                if (phase == 2'd3) begin
                    if (ox == X_BITS'(OUT_W - 1)) begin
                        ox <= '0;
                        oy <= oy + 1'b1;
                        issuing <= !last_block;
                    end else begin
                        ox <= ox + 1'b1;
                    end
                end
            end else if (wr_last) begin
                busy_o <= 1'b0;
            end
            rd_valid <= issuing;    // read data is one cycle behind
            rd_phase <= phase;
            rd_last <= issuing && phase == 2'd3 && last_block;
            dst_we_o <= rd_valid && rd_phase == 2'd3;
            wr_last <= rd_last;
            done_o <= wr_last;
        end
    end

    always_ff @(posedge clk_100mhz) begin
        rd_addr <= DST_BITS'(oy * OUT_W + ox);
        if (rd_valid) begin
            sum <= block_sum;
        end
        dst_addr_o <= rd_addr;
        dst_data_o <= block_sum[BLOCK_SUM_BITS-1:2];    // floor of sum / 4
    end

    assert property (@(posedge clk_100mhz) disable iff (sys_rst) !(start_i && busy_o));

endmodule

`default_nettype wire

/* verilog/image_pkg.sv */
`default_nettype none

package image_pkg;

    localparam int PIXEL_BITS = 8;

    // four pixels summed need two extra bits
    localparam int BLOCK_SUM_BITS = PIXEL_BITS + 2;

    // one greyscale pixel, also one uart byte
    typedef logic [PIXEL_BITS-1:0] pixel_t;

endpackage

`default_nettype wire

/* verilog/pixel_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_ram
    import image_pkg::*;
#(
    parameter int DEPTH = 4096
) (
    input wire clk_100mhz,
    input wire we_i,
    input wire logic [$clog2(DEPTH)-1:0] waddr_i,
    input wire pixel_t wdata_i,
    input wire logic [$clog2(DEPTH)-1:0] raddr_i,
    output pixel_t rdata_o
);
    pixel_t mem [DEPTH];

    always_ff @(posedge clk_100mhz) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        rdata_o <= mem[raddr_i];    // one cycle read
    end

    // writers compute addresses from image geometry
    assert property (@(posedge clk_100mhz) we_i |-> (waddr_i < DEPTH));

endmodule

`default_nettype wire

/* verilog/pyramid_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module pyramid_controller
    import image_pkg::*;
#(
    parameter int IMG_WIDTH = 64,
    parameter int IMG_HEIGHT = 64
) (
    input wire clk_100mhz,
    input wire sys_rst,
    input wire rx_valid_i,
    output logic img_we_o,
    output logic [$clog2(IMG_WIDTH*IMG_HEIGHT)-1:0] img_waddr_o,
    output logic ds_start_o,
    input wire ds_done_i,
    input wire send_i,
    output logic [$clog2(IMG_WIDTH*IMG_HEIGHT/4)-1:0] red_raddr_o,
    input wire pixel_t red_data_i,
    output logic tx_start_o,
    output pixel_t tx_data_o,
    input wire tx_busy_i,
    output logic image_ready_o,
    output logic reduced_ready_o,
    output logic sending_o
);
    localparam int NUM_PIXELS = IMG_WIDTH * IMG_HEIGHT;
    localparam int NUM_REDUCED = NUM_PIXELS / 4;
    localparam int IMG_BITS = $clog2(NUM_PIXELS);
    localparam int RED_BITS = $clog2(NUM_REDUCED);

    typedef enum logic [1:0] {ST_IDLE, ST_FETCH, ST_ISSUE, ST_DRAIN} tx_state_t;

    tx_state_t state;
    logic send_q;
    logic send_edge;

    assign img_we_o = rx_valid_i && !image_ready_o;    // extra bytes dropped
    assign send_edge = send_i && !send_q;

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            img_waddr_o <= '0;
            image_ready_o <= 1'b0;
            ds_start_o <= 1'b0;
            reduced_ready_o <= 1'b0;
        end else begin
            ds_start_o <= 1'b0;
            if (img_we_o) begin
                img_waddr_o <= img_waddr_o + 1'b1;
                if (img_waddr_o == IMG_BITS'(NUM_PIXELS - 1)) begin
                    image_ready_o <= 1'b1;
                    ds_start_o <= 1'b1;
                end
            end
            if (ds_done_i) begin
                reduced_ready_o <= 1'b1;
            end
        end
    end

    // send sequencing, one reduced pixel per frame
    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            state <= ST_IDLE;
            send_q <= 1'b0;
            sending_o <= 1'b0;
            tx_start_o <= 1'b0;
            red_raddr_o <= '0;
        end else begin
            send_q <= send_i;
            tx_start_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (send_edge && reduced_ready_o) begin
                        sending_o <= 1'b1;
                        red_raddr_o <= '0;
                        state <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    state <= ST_ISSUE;    // ram read in flight
                end
                ST_ISSUE: begin
                    if (!tx_busy_i) begin
                        tx_start_o <= 1'b1;
                        if (red_raddr_o == RED_BITS'(NUM_REDUCED - 1)) begin
                            state <= ST_DRAIN;
                        end else begin
                            red_raddr_o <= red_raddr_o + 1'b1;
                            state <= ST_FETCH;
                        end
                    end
                end
                ST_DRAIN: begin
                    // busy rises a cycle after the start strobe
                    if (!tx_start_o && !tx_busy_i) begin
                        sending_o <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (state == ST_ISSUE && !tx_busy_i) begin
            tx_data_o <= red_data_i;
        end
    end

endmodule

`default_nettype wire

/* verilog/pyramid_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pyramid_top
    import image_pkg::*;
#(
    parameter int IMG_WIDTH = 64,
    parameter int IMG_HEIGHT = 64,
    parameter int CLOCKS_PER_BAUD = 50
) (
    input wire clk_100mhz,
    input wire sys_rst,
    input wire uart_rxd_i,
    input wire send_i,
    output logic uart_txd_o,
    output logic image_ready_o,
    output logic reduced_ready_o,
    output logic sending_o
);
    localparam int NUM_PIXELS = IMG_WIDTH * IMG_HEIGHT;
    localparam int IMG_BITS = $clog2(NUM_PIXELS);
    localparam int RED_BITS = $clog2(NUM_PIXELS / 4);

    pixel_t rx_data;
    logic rx_valid;
    logic img_we;
    logic [IMG_BITS-1:0] img_waddr;
    logic [IMG_BITS-1:0] img_raddr;
    pixel_t img_rdata;
    logic ds_start;
    logic ds_done;
    logic red_we;
    logic [RED_BITS-1:0] red_waddr;
    pixel_t red_wdata;
    logic [RED_BITS-1:0] red_raddr;
    pixel_t red_rdata;
    logic tx_start;
    pixel_t tx_data;
    logic tx_busy;

    uart_receiver #(.CLOCKS_PER_BAUD(CLOCKS_PER_BAUD)) urx0 (
        .clk_100mhz(clk_100mhz), .sys_rst(sys_rst), .rxd_i(uart_rxd_i),
        .data_o(rx_data), .valid_o(rx_valid)
    );

    pixel_ram #(.DEPTH(NUM_PIXELS)) img_ram0 (    // full size input image
        .clk_100mhz(clk_100mhz), .we_i(img_we), .waddr_i(img_waddr),
        .wdata_i(rx_data), .raddr_i(img_raddr), .rdata_o(img_rdata)
    );

    pixel_ram #(.DEPTH(NUM_PIXELS / 4)) red_ram0 (
        .clk_100mhz(clk_100mhz), .we_i(red_we), .waddr_i(red_waddr),
        .wdata_i(red_wdata), .raddr_i(red_raddr), .rdata_o(red_rdata)
    );

    box_downsampler #(.IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT)) ds0 (
        .clk_100mhz(clk_100mhz), .sys_rst(sys_rst), .start_i(ds_start),
        .busy_o(), .done_o(ds_done),    // busy level is status only
        .src_addr_o(img_raddr), .src_data_i(img_rdata),
        .dst_we_o(red_we), .dst_addr_o(red_waddr), .dst_data_o(red_wdata)
    );

    pyramid_controller #(.IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT)) ctrl0 (
        .clk_100mhz(clk_100mhz), .sys_rst(sys_rst), .rx_valid_i(rx_valid),
        .img_we_o(img_we), .img_waddr_o(img_waddr), .ds_start_o(ds_start),
        .ds_done_i(ds_done), .send_i(send_i), .red_raddr_o(red_raddr),
        .red_data_i(red_rdata), .tx_start_o(tx_start), .tx_data_o(tx_data),
        .tx_busy_i(tx_busy), .image_ready_o(image_ready_o),
        .reduced_ready_o(reduced_ready_o), .sending_o(sending_o)
    );

    uart_transmitter #(.CLOCKS_PER_BAUD(CLOCKS_PER_BAUD)) utx0 (
        .clk_100mhz(clk_100mhz), .sys_rst(sys_rst), .start_i(tx_start),
        .data_i(tx_data), .busy_o(tx_busy), .txd_o(uart_txd_o)
    );

endmodule

`default_nettype wire

/* verilog/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    localparam int UART_DATA_BITS = 8;    // lsb first

    // start + data + stop
    localparam int UART_FRAME_BITS = UART_DATA_BITS + 2;

    // position within a frame, 0 is the start bit
    typedef logic [3:0] uart_bit_idx_t;

endpackage

`default_nettype wire

/* verilog/uart_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_receiver
    import uart_pkg::*;
    import image_pkg::*;
#(
    parameter int CLOCKS_PER_BAUD = 50
) (
    input wire clk_100mhz,
    input wire sys_rst,
    input wire rxd_i,
    output pixel_t data_o,
    output logic valid_o
);
    localparam int CNT_BITS = $clog2(CLOCKS_PER_BAUD);
    localparam logic [CNT_BITS-1:0] BAUD_LAST = CNT_BITS'(CLOCKS_PER_BAUD - 1);
    localparam logic [CNT_BITS-1:0] BAUD_HALF = CNT_BITS'(CLOCKS_PER_BAUD / 2);

    logic rxd_meta;
    logic rxd_sync;
    logic active;
    logic sample;
    logic [CNT_BITS-1:0] baud_cnt;
    uart_bit_idx_t bit_idx;

    assign sample = active && (baud_cnt == '0);

    // two flop synchroniser, line idles high
    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd_i;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            active <= 1'b0;
            baud_cnt <= '0;
            bit_idx <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            if (!active) begin
                if (!rxd_sync) begin
                    active <= 1'b1;
                    baud_cnt <= BAUD_HALF;    // first look lands mid start bit
                    bit_idx <= '0;
                end
            end else if (baud_cnt != '0) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else begin
                baud_cnt <= BAUD_LAST;
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == '0) begin
                    active <= !rxd_sync;    // drop a glitch on the line
                end else if (bit_idx == uart_bit_idx_t'(UART_FRAME_BITS - 1)) begin
                    active <= 1'b0;
                    valid_o <= rxd_sync;    // framing error gives no strobe
                end
            end
        end
    end

    // data bits shift in from the top
    always_ff @(posedge clk_100mhz) begin
        if (sample && bit_idx != '0 && bit_idx <= uart_bit_idx_t'(UART_DATA_BITS)) begin
            data_o <= {rxd_sync, data_o[PIXEL_BITS-1:1]};
        end
    end

endmodule

`default_nettype wire

/* verilog/uart_transmitter.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_transmitter
    import uart_pkg::*;
    import image_pkg::*;
#(
    parameter int CLOCKS_PER_BAUD = 50
) (
    input wire clk_100mhz,
    input wire sys_rst,
    input wire start_i,
    input wire pixel_t data_i,
    output logic busy_o,
    output logic txd_o
);
    localparam int CNT_BITS = $clog2(CLOCKS_PER_BAUD);
    localparam logic [CNT_BITS-1:0] BAUD_LAST = CNT_BITS'(CLOCKS_PER_BAUD - 1);

    logic [CNT_BITS-1:0] baud_cnt;
    uart_bit_idx_t bit_idx;
    logic [UART_DATA_BITS:0] shift_q;    // data with the stop bit on top

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            busy_o <= 1'b0;
            txd_o <= 1'b1;
            baud_cnt <= '0;
            bit_idx <= '0;
        end else if (!busy_o) begin
            if (start_i) begin
                busy_o <= 1'b1;
                txd_o <= 1'b0;    // start bit
                baud_cnt <= BAUD_LAST;
                bit_idx <= '0;
            end
        end else if (baud_cnt != '0) begin
            baud_cnt <= baud_cnt - 1'b1;
        end else if (bit_idx == uart_bit_idx_t'(UART_FRAME_BITS - 1)) begin
            busy_o <= 1'b0;    // stop bit done, line stays high
        end else begin
            txd_o <= shift_q[0];
            baud_cnt <= BAUD_LAST;
            bit_idx <= bit_idx + 1'b1;
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (start_i && !busy_o) begin
            shift_q <= {1'b1, data_i};
        end else if (busy_o && baud_cnt == '0) begin
            shift_q <= {1'b1, shift_q[UART_DATA_BITS:1]};
        end
    end

    // controller must wait for the frame in flight
    assert property (@(posedge clk_100mhz) disable iff (sys_rst) !(start_i && busy_o));

endmodule

`default_nettype wire
